// File: Makefile
# Verilator build and run for the data memory region testbench

VERILATOR ?= verilator
TOP       ?= tb_mem_region
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert --timing --timescale 1ns/100ps
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= NO ERRORS

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: apb_bus_master.sv
//**********************************************************
// APB master for remote core accesses
// one transfer per core request, grant at pready
//**********************************************************

module apb_bus_master import mem_region_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  bus_req_i,
  input  addr_t req_addr_i,
  input  logic  req_we_i,
  input  be_t   req_be_i,
  input  data_t req_wdata_i,
  output logic  bus_gnt_o,
  output logic  bus_rvalid_o,
  output data_t bus_rdata_o,
  output logic  m_psel_o,
  output logic  m_penable_o,
  output logic  m_pwrite_o,
  output addr_t m_paddr_o,
  output data_t m_pwdata_o,
  output be_t   m_pstrb_o,
  input  logic  m_pready_i,
  input  data_t m_prdata_i
);

  typedef enum logic [1:0] {
    IDLE,
    SETUP,
    ACCESS
  } state_e;

  state_e state_q;
  logic   done;
  logic   rvalid_q;

  assign done = (state_q == ACCESS) & m_pready_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= IDLE;
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= done;
      case (state_q)
        IDLE:    if (bus_req_i) state_q <= SETUP;
        SETUP:   state_q <= ACCESS;
        ACCESS:  if (m_pready_i) state_q <= IDLE;
        default: state_q <= IDLE;
      endcase
    end
  end

  // transfer fields held from setup until pready
  always_ff @(posedge clk) begin
    if (state_q == IDLE && bus_req_i) begin
      m_paddr_o  <= req_addr_i;
      m_pwrite_o <= req_we_i;
      m_pwdata_o <= req_wdata_i;
      m_pstrb_o  <= req_be_i;
    end
    if (done) begin
      bus_rdata_o <= m_prdata_i;
    end
  end

  assign m_psel_o     = (state_q != IDLE);
  assign m_penable_o  = (state_q == ACCESS);
  assign bus_gnt_o    = done;
  assign bus_rvalid_o = rvalid_q;

endmodule

// File: apb_mem_slave.sv
//**********************************************************
// APB slave into the data RAM
// every transfer is setup plus two access cycles
//**********************************************************

module apb_mem_slave import mem_region_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  s_psel_i,
  input  logic  s_penable_i,
  input  logic  s_pwrite_i,
  input  addr_t s_paddr_i,
  input  data_t s_pwdata_i,
  output logic  s_pready_o,
  output data_t s_prdata_o,
  output logic  p0_req_o,
  output addr_t p0_addr_o,
  output logic  p0_we_o,
  output data_t p0_wdata_o,
  input  data_t p0_rdata_i
);

  logic access;
  // low in the first access cycle, high in the second
  logic phase_q;

  assign access = s_psel_i & s_penable_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase_q <= 1'b0;
    end else if (access) begin
      phase_q <= ~phase_q;
    end
  end

  // RAM request only in the first access cycle
  assign p0_req_o   = access & ~phase_q;
  assign p0_addr_o  = s_paddr_i;
  assign p0_we_o    = s_pwrite_i;
  assign p0_wdata_o = s_pwdata_i;

  // RAM output is valid one cycle after the request
  assign s_pready_o = access & phase_q;
  assign s_prdata_o = p0_rdata_i;

endmodule

// File: build.f
mem_region_pkg.sv
lsu_demux.sv
apb_mem_slave.sv
ram_arbiter.sv
data_sram.sv
apb_bus_master.sv
mem_region_top.sv
mem_region_checker.sv
tb_mem_region.sv

// File: data_sram.sv
//**********************************************************
// data RAM
// single port, byte lane writes, registered read data
//**********************************************************

module data_sram import mem_region_pkg::*; #(
  parameter int unsigned RAM_WORDS = 1024
) (
  input  logic  clk,
  input  logic  en_i,
  input  logic [((RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1)-1:0] index_i,
  input  logic  we_i,
  input  be_t   be_i,
  input  data_t wdata_i,
  output data_t rdata_o
);

  localparam int unsigned LANES = $bits(be_t);

  data_t mem [RAM_WORDS];

  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        for (int lane = 0; lane < LANES; lane++) begin
          if (be_i[lane]) begin
            mem[index_i][8*lane +: 8] <= wdata_i[8*lane +: 8];
          end
        end
      end else begin
        // output holds until the next enabled read
        rdata_o <= mem[index_i];
      end
    end
  end

endmodule

// File: lsu_demux.sv
//**********************************************************
// core load/store demux
// splits core requests between data RAM and APB master,
// tracks the response source and returns read data
//**********************************************************

module lsu_demux import mem_region_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  lsu_req_i,
  input  addr_t lsu_addr_i,
  input  logic  lsu_we_i,
  input  be_t   lsu_be_i,
  input  data_t lsu_wdata_i,
  output logic  lsu_gnt_o,
  output logic  lsu_rvalid_o,
  output data_t lsu_rdata_o,
  output logic  ram_req_o,
  input  logic  ram_gnt_i,
  input  logic  ram_rvalid_i,
  input  data_t ram_rdata_i,
  output logic  bus_req_o,
  input  logic  bus_gnt_i,
  input  logic  bus_rvalid_i,
  input  data_t bus_rdata_i,
  output addr_t req_addr_o,
  output logic  req_we_o,
  output be_t   req_be_o,
  output data_t req_wdata_o
);

  page_t     req_page;
  logic      is_local;
  resp_src_e resp_src_q;

  assign req_page = lsu_addr_i[31:20];
  assign is_local = (req_page == LOCAL_PAGE);

  // exactly one target sees the request
  assign ram_req_o = lsu_req_i & is_local;
  assign bus_req_o = lsu_req_i & ~is_local;

  // shared payload for both targets
  assign req_addr_o  = lsu_addr_i;
  assign req_we_o    = lsu_we_i;
  assign req_be_o    = lsu_be_i;
  assign req_wdata_o = lsu_wdata_i;

  assign lsu_gnt_o = (ram_req_o & ram_gnt_i) | (bus_req_o & bus_gnt_i);

  // remember where the granted access went
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_src_q <= RESP_RAM;
    end else if (lsu_gnt_o) begin
      resp_src_q <= is_local ? RESP_RAM : RESP_BUS;
    end
  end

  assign lsu_rvalid_o = ram_rvalid_i | bus_rvalid_i;
  assign lsu_rdata_o  = (resp_src_q == RESP_BUS) ? bus_rdata_i : ram_rdata_i;

endmodule

// File: mem_region_checker.sv
//************************************************************
// memory region protocol checker
// APB master stability, core response timing, RAM priority
// and slave pready timing
//************************************************************

module mem_region_checker import mem_region_pkg::*; (
  input logic  clk,
  input logic  rst_n,
  input logic  lsu_req_i,
  input addr_t lsu_addr_i,
  input logic  lsu_gnt_i,
  input logic  lsu_rvalid_i,
  input logic  p0_req_i,
  input logic  s_psel_i,
  input logic  s_penable_i,
  input logic  s_pready_i,
  input logic  m_psel_i,
  input logic  m_penable_i,
  input logic  m_pready_i,
  input addr_t m_paddr_i
);

  timeunit 1ns;
  timeprecision 100ps;

  // number of failed assertions so far
  int fail_count = 0;

  // transfer held from setup until the responder is ready
  a_master_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (m_psel_i && !(m_penable_i && m_pready_i)) |=> (m_psel_i && $stable(m_paddr_i)))
  else begin
    fail_count = fail_count + 1;
    $error("APB master dropped psel or changed paddr before pready");
  end

  a_local_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
    (lsu_gnt_i && lsu_addr_i[31:20] == LOCAL_PAGE) |=> lsu_rvalid_i)
  else begin
    fail_count = fail_count + 1;
    $error("local grant not followed by rvalid one cycle later");
  end

  // slave port owns the RAM in its request cycle
  a_slave_priority: assert property (@(posedge clk) disable iff (!rst_n)
    (p0_req_i && lsu_req_i && lsu_addr_i[31:20] == LOCAL_PAGE) |-> !lsu_gnt_i)
  else begin
    fail_count = fail_count + 1;
    $error("core granted the RAM while the slave port requested it");
  end

  // second access cycle means one access cycle after setup
  a_slave_ready: assert property (@(posedge clk) disable iff (!rst_n)
    s_pready_i |-> (s_psel_i && s_penable_i && $past(s_psel_i && s_penable_i)
                    && $past(s_psel_i && !s_penable_i, 2)))
  else begin
    fail_count = fail_count + 1;
    $error("slave pready outside the second access cycle");
  end

endmodule

bind mem_region_top mem_region_checker u_chk (
  .clk          (clk),
  .rst_n        (rst_n),
  .lsu_req_i    (lsu_req_i),
  .lsu_addr_i   (lsu_addr_i),
  .lsu_gnt_i    (lsu_gnt_o),
  .lsu_rvalid_i (lsu_rvalid_o),
  .p0_req_i     (p0_req),
  .s_psel_i     (s_psel_i),
  .s_penable_i  (s_penable_i),
  .s_pready_i   (s_pready_o),
  .m_psel_i     (m_psel_o),
  .m_penable_i  (m_penable_o),
  .m_pready_i   (m_pready_i),
  .m_paddr_i    (m_paddr_o)
);

// File: mem_region_pkg.sv
//**********************************************************
// memory region package
// shared widths, local page tag and response source
//**********************************************************

package mem_region_pkg;

  // byte address of a core or bus access
  typedef logic [31:0] addr_t;

  // one data word
  typedef logic [31:0] data_t;

  // one enable bit per byte lane
  typedef logic [3:0] be_t;

  // upper address bits that tag a region
  typedef logic [11:0] page_t;

  // page served by the data RAM
  localparam page_t LOCAL_PAGE = 12'h001;

  // origin of the next core response
  typedef enum logic [0:0] {
    RESP_RAM = 1'b0,
    RESP_BUS = 1'b1
  } resp_src_e;

endpackage

// File: mem_region_top.sv
//**********************************************************
// data memory region
// core port routed to the data RAM or the APB master,
// external APB slave shares the RAM with priority
//**********************************************************

module mem_region_top import mem_region_pkg::*; #(
  parameter int unsigned RAM_WORDS = 1024
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  lsu_req_i,
  input  addr_t lsu_addr_i,
  input  logic  lsu_we_i,
  input  be_t   lsu_be_i,
  input  data_t lsu_wdata_i,
  output logic  lsu_gnt_o,
  output logic  lsu_rvalid_o,
  output data_t lsu_rdata_o,
  input  logic  s_psel_i,
  input  logic  s_penable_i,
  input  logic  s_pwrite_i,
  input  addr_t s_paddr_i,
  input  data_t s_pwdata_i,
  output logic  s_pready_o,
  output data_t s_prdata_o,
  output logic  m_psel_o,
  output logic  m_penable_o,
  output logic  m_pwrite_o,
  output addr_t m_paddr_o,
  output data_t m_pwdata_o,
  output be_t   m_pstrb_o,
  input  logic  m_pready_i,
  input  data_t m_prdata_i
);

  localparam int unsigned IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  // core side, after the address decode
  logic  ram_req, ram_gnt, ram_rvalid;
  logic  bus_req, bus_gnt, bus_rvalid;
  data_t ram_rdata, bus_rdata;
  addr_t req_addr;
  logic  req_we;
  be_t   req_be;
  data_t req_wdata;

  // APB slave into the arbiter
  logic  p0_req, p0_we;
  addr_t p0_addr;
  data_t p0_wdata, p0_rdata;

  // arbiter to RAM
  logic             sram_en, sram_we;
  logic [IDX_W-1:0] sram_index;
  be_t              sram_be;
  data_t            sram_wdata, sram_rdata;

  lsu_demux u_demux (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req_i),
    .lsu_addr_i   (lsu_addr_i),
    .lsu_we_i     (lsu_we_i),
    .lsu_be_i     (lsu_be_i),
    .lsu_wdata_i  (lsu_wdata_i),
    .lsu_gnt_o    (lsu_gnt_o),
    .lsu_rvalid_o (lsu_rvalid_o),
    .lsu_rdata_o  (lsu_rdata_o),
    .ram_req_o    (ram_req),
    .ram_gnt_i    (ram_gnt),
    .ram_rvalid_i (ram_rvalid),
    .ram_rdata_i  (ram_rdata),
    .bus_req_o    (bus_req),
    .bus_gnt_i    (bus_gnt),
    .bus_rvalid_i (bus_rvalid),
    .bus_rdata_i  (bus_rdata),
    .req_addr_o   (req_addr),
    .req_we_o     (req_we),
    .req_be_o     (req_be),
    .req_wdata_o  (req_wdata)
  );

  apb_mem_slave u_slave (
    .clk         (clk),
    .rst_n       (rst_n),
    .s_psel_i    (s_psel_i),
    .s_penable_i (s_penable_i),
    .s_pwrite_i  (s_pwrite_i),
    .s_paddr_i   (s_paddr_i),
    .s_pwdata_i  (s_pwdata_i),
    .s_pready_o  (s_pready_o),
    .s_prdata_o  (s_prdata_o),
    .p0_req_o    (p0_req),
    .p0_addr_o   (p0_addr),
    .p0_we_o     (p0_we),
    .p0_wdata_o  (p0_wdata),
    .p0_rdata_i  (p0_rdata)
  );

  ram_arbiter #(
    .RAM_WORDS (RAM_WORDS)
  ) u_arb (
    .clk         (clk),
    .rst_n       (rst_n),
    .p0_req_i    (p0_req),
    .p0_addr_i   (p0_addr),
    .p0_we_i     (p0_we),
    .p0_wdata_i  (p0_wdata),
    .p0_rdata_o  (p0_rdata),
    .p1_req_i    (ram_req),
    .p1_addr_i   (req_addr),
    .p1_we_i     (req_we),
    .p1_be_i     (req_be),
    .p1_wdata_i  (req_wdata),
    .p1_gnt_o    (ram_gnt),
    .p1_rvalid_o (ram_rvalid),
    .p1_rdata_o  (ram_rdata),
    .ram_en_o    (sram_en),
    .ram_index_o (sram_index),
    .ram_we_o    (sram_we),
    .ram_be_o    (sram_be),
    .ram_wdata_o (sram_wdata),
    .ram_rdata_i (sram_rdata)
  );

  data_sram #(
    .RAM_WORDS (RAM_WORDS)
  ) u_sram (
    .clk     (clk),
    .en_i    (sram_en),
    .index_i (sram_index),
    .we_i    (sram_we),
    .be_i    (sram_be),
    .wdata_i (sram_wdata),
    .rdata_o (sram_rdata)
  );

  apb_bus_master u_master (
    .clk          (clk),
    .rst_n        (rst_n),
    .bus_req_i    (bus_req),
    .req_addr_i   (req_addr),
    .req_we_i     (req_we),
    .req_be_i     (req_be),
    .req_wdata_i  (req_wdata),
    .bus_gnt_o    (bus_gnt),
    .bus_rvalid_o (bus_rvalid),
    .bus_rdata_o  (bus_rdata),
    .m_psel_o     (m_psel_o),
    .m_penable_o  (m_penable_o),
    .m_pwrite_o   (m_pwrite_o),
    .m_paddr_o    (m_paddr_o),
    .m_pwdata_o   (m_pwdata_o),
    .m_pstrb_o    (m_pstrb_o),
    .m_pready_i   (m_pready_i),
    .m_prdata_i   (m_prdata_i)
  );

endmodule

// File: ram_arbiter.sv
//**********************************************************
// data RAM arbiter
// fixed priority, APB slave port over the core port
//**********************************************************

module ram_arbiter import mem_region_pkg::*; #(
  parameter int unsigned RAM_WORDS = 1024
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  p0_req_i,
  input  addr_t p0_addr_i,
  input  logic  p0_we_i,
  input  data_t p0_wdata_i,
  output data_t p0_rdata_o,
  input  logic  p1_req_i,
  input  addr_t p1_addr_i,
  input  logic  p1_we_i,
  input  be_t   p1_be_i,
  input  data_t p1_wdata_i,
  output logic  p1_gnt_o,
  output logic  p1_rvalid_o,
  output data_t p1_rdata_o,
  output logic  ram_en_o,
  output logic [((RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1)-1:0] ram_index_o,
  output logic  ram_we_o,
  output be_t   ram_be_o,
  output data_t ram_wdata_o,
  input  data_t ram_rdata_i
);

  localparam int unsigned IDX_W = (RAM_WORDS > 1) ? $clog2(RAM_WORDS) : 1;

  logic p1_rvalid_q;

  // core only gets the RAM when port0 is idle
  assign p1_gnt_o = p1_req_i & ~p0_req_i;
  assign ram_en_o = p0_req_i | p1_req_i;

  always_comb begin
    if (p0_req_i) begin
      ram_index_o = p0_addr_i[IDX_W+1:2];
      ram_we_o    = p0_we_i;
      // slave writes are always full word
      ram_be_o    = '1;
      ram_wdata_o = p0_wdata_i;
    end else begin
      ram_index_o = p1_addr_i[IDX_W+1:2];
      ram_we_o    = p1_we_i;
      ram_be_o    = p1_be_i;
      ram_wdata_o = p1_wdata_i;
    end
  end

  // one response per core grant, read or write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      p1_rvalid_q <= 1'b0;
    end else begin
      p1_rvalid_q <= p1_gnt_o;
    end
  end

  assign p1_rvalid_o = p1_rvalid_q;
  assign p1_rdata_o  = ram_rdata_i;
  assign p0_rdata_o  = ram_rdata_i;

endmodule

// File: tb_mem_region.sv
//************************************************************
// testbench for the data memory region
// core, APB slave and APB responder traffic checked
// against a reference copy of the data RAM
//************************************************************

module tb_mem_region import mem_region_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int WORDS   = 16;
  localparam int TIMEOUT = 50;

  logic  clk, rst_n;
  logic  lsu_req, lsu_we, lsu_gnt, lsu_rvalid;
  addr_t lsu_addr;
  be_t   lsu_be;
  data_t lsu_wdata, lsu_rdata;
  logic  s_psel, s_penable, s_pwrite, s_pready;
  addr_t s_paddr;
  data_t s_pwdata, s_prdata;
  logic  m_psel, m_penable, m_pwrite, m_pready;
  addr_t m_paddr;
  data_t m_pwdata, m_prdata;
  be_t   m_pstrb;

  // master port fields seen at pready
  addr_t cap_addr;
  data_t cap_wdata;
  logic  cap_write;
  be_t   cap_strb;

  data_t       ref_mem [WORDS];
  logic [31:0] seed = 32'h761d73da;

  mem_region_top #(
    .RAM_WORDS (1024)
  ) u_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .lsu_req_i    (lsu_req),
    .lsu_addr_i   (lsu_addr),
    .lsu_we_i     (lsu_we),
    .lsu_be_i     (lsu_be),
    .lsu_wdata_i  (lsu_wdata),
    .lsu_gnt_o    (lsu_gnt),
    .lsu_rvalid_o (lsu_rvalid),
    .lsu_rdata_o  (lsu_rdata),
    .s_psel_i     (s_psel),
    .s_penable_i  (s_penable),
    .s_pwrite_i   (s_pwrite),
    .s_paddr_i    (s_paddr),
    .s_pwdata_i   (s_pwdata),
    .s_pready_o   (s_pready),
    .s_prdata_o   (s_prdata),
    .m_psel_o     (m_psel),
    .m_penable_o  (m_penable),
    .m_pwrite_o   (m_pwrite),
    .m_paddr_o    (m_paddr),
    .m_pwdata_o   (m_pwdata),
    .m_pstrb_o    (m_pstrb),
    .m_pready_i   (m_pready),
    .m_prdata_i   (m_prdata)
  );

  // xorshift32
  function automatic logic [31:0] next_rand();
    seed = seed ^ (seed << 13);
    seed = seed ^ (seed >> 17);
    seed = seed ^ (seed << 5);
    return seed;
  endfunction

  function automatic addr_t local_addr(int idx);
    return {LOCAL_PAGE, 18'(idx), 2'b00};
  endfunction

  // top nibble 8 keeps the page away from the RAM
  function automatic addr_t remote_addr();
    logic [31:0] r;
    r = next_rand();
    return {4'h8, r[27:2], 2'b00};
  endfunction

  function automatic data_t merge_lanes(data_t old, data_t wd, be_t be);
    data_t res;
    res = old;
    for (int k = 0; k < 4; k++) begin
      if (be[k]) begin
        res[8*k +: 8] = wd[8*k +: 8];
      end
    end
    return res;
  endfunction

  task automatic check_value(input string name, input data_t exp, input data_t act);
    assert (act === exp) else begin
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
      $display("ERRORS FOUND");
      $fatal(1, "value mismatch");
    end
  endtask

  task automatic check_idle();
    check_value("lsu_gnt_o", 32'd0, {31'b0, lsu_gnt});
    check_value("lsu_rvalid_o", 32'd0, {31'b0, lsu_rvalid});
    check_value("m_psel_o", 32'd0, {31'b0, m_psel});
    check_value("s_pready_o", 32'd0, {31'b0, s_pready});
  endtask

  // one more cycle of waiting, bounded
  task automatic tick_or_fail(inout int count, input string what);
    count++;
    if (count > TIMEOUT) begin
      $display("timeout: no %s within %0d cycles", what, TIMEOUT);
      $display("ERRORS FOUND");
      $fatal(1, "timeout");
    end else begin
      @(negedge clk);
    end
  endtask

  // starts and ends on a falling edge
  task automatic core_access(input addr_t addr, input logic we, input be_t be,
                             input data_t wdata, output data_t rdata);
    int count;
    count    = 0;
    lsu_req  = 1'b1;
    lsu_addr = addr;
    lsu_we   = we;
    lsu_be   = be;
    lsu_wdata = wdata;
    #1;
    while (!lsu_gnt) begin
      tick_or_fail(count, "lsu_gnt_o");
      #1;
    end
    if (addr[31:20] != LOCAL_PAGE) begin
      check_value("m_pready_i at grant", 32'd1, {31'b0, m_pready});
    end
    @(negedge clk);
    lsu_req = 1'b0;
    count   = 0;
    #1;
    while (!lsu_rvalid) begin
      tick_or_fail(count, "lsu_rvalid_o");
      #1;
    end
    check_value("lsu_rvalid_o delay", 32'd0, count);
    rdata = lsu_rdata;
    @(negedge clk);
  endtask

  // APB transfer on the slave port, setup plus two access cycles
  task automatic slave_xfer(input logic write, input addr_t addr, input data_t wdata,
                            output data_t rdata);
    int count;
    count     = 0;
    s_psel    = 1'b1;
    s_penable = 1'b0;
    s_pwrite  = write;
    s_paddr   = addr;
    s_pwdata  = wdata;
    @(negedge clk);
    s_penable = 1'b1;
    #1;
    while (!s_pready) begin
      tick_or_fail(count, "s_pready_o");
      #1;
    end
    check_value("s_pready_o access cycles", 32'd2, count + 1);
    rdata = s_prdata;
    @(negedge clk);
    s_psel    = 1'b0;
    s_penable = 1'b0;
  endtask

  initial begin : clock_gen
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // APB responder with 0 to 3 wait states
  initial begin : apb_responder
    int          wait_left;
    logic [31:0] r;
    wait_left = 0;
    forever begin
      @(negedge clk);
      m_pready = 1'b0;
      if (m_psel && !m_penable) begin
        r = next_rand();
        wait_left = r % 4;
      end else if (m_psel && m_penable) begin
        if (wait_left == 0) begin
          m_pready  = 1'b1;
          m_prdata  = m_paddr ^ 32'hA5A5A5A5;
          cap_addr  = m_paddr;
          cap_write = m_pwrite;
          cap_wdata = m_pwdata;
          cap_strb  = m_pstrb;
        end else begin
          wait_left = wait_left - 1;
        end
      end
    end
  end

  always @(negedge clk) begin
    if (u_dut.u_chk.fail_count != 0) begin
      $display("ERRORS FOUND");
      $fatal(1, "protocol assertion failed");
    end
  end

  initial begin : stimulus
    data_t       rd, rd_s, rd_c, wd, sd;
    addr_t       addr;
    logic [31:0] r;
    int          i, idx, a, b;
    be_t         be;
    rst_n = 1'b0;
    lsu_req = 1'b0;
    lsu_addr = '0;
    lsu_we = 1'b0;
    lsu_be = '0;
    lsu_wdata = '0;
    s_psel = 1'b0;
    s_penable = 1'b0;
    s_pwrite = 1'b0;
    s_paddr = '0;
    s_pwdata = '0;
    m_pready = 1'b0;
    m_prdata = '0;
    repeat (4) @(negedge clk);
    check_idle();
    rst_n = 1'b1;
    @(negedge clk);
    check_idle();

    // local writes, byte lane merges, then read back
    for (idx = 0; idx < WORDS; idx++) begin
      wd = next_rand();
      core_access(local_addr(idx), 1'b1, 4'hF, wd, rd);
      ref_mem[idx] = wd;
    end
    for (i = 0; i < 40; i++) begin
      r = next_rand();
      idx = r % WORDS;
      be = r[7:4];
      wd = next_rand();
      core_access(local_addr(idx), 1'b1, be, wd, rd);
      ref_mem[idx] = merge_lanes(ref_mem[idx], wd, be);
    end
    for (idx = 0; idx < WORDS; idx++) begin
      core_access(local_addr(idx), 1'b0, 4'hF, 32'd0, rd);
      check_value("lsu_rdata_o", ref_mem[idx], rd);
    end

    // remote accesses through the APB master
    for (i = 0; i < 12; i++) begin
      r = next_rand();
      addr = remote_addr();
      wd = next_rand();
      core_access(addr, r[0], r[7:4], wd, rd);
      check_value("m_paddr_o", addr, cap_addr);
      check_value("m_pwrite_o", {31'b0, r[0]}, {31'b0, cap_write});
      check_value("m_pwdata_o", wd, cap_wdata);
      check_value("m_pstrb_o", {28'b0, r[7:4]}, {28'b0, cap_strb});
      if (!r[0]) begin
        check_value("lsu_rdata_o", addr ^ 32'hA5A5A5A5, rd);
      end
    end

    // RAM shared between slave port and core
    for (i = 0; i < 8; i++) begin
      r = next_rand();
      idx = r % WORDS;
      wd = next_rand();
      slave_xfer(1'b1, local_addr(idx), wd, rd);
      ref_mem[idx] = wd;
      core_access(local_addr(idx), 1'b0, 4'hF, 32'd0, rd);
      check_value("lsu_rdata_o", ref_mem[idx], rd);
      r = next_rand();
      idx = r % WORDS;
      wd = next_rand();
      core_access(local_addr(idx), 1'b1, r[7:4], wd, rd);
      ref_mem[idx] = merge_lanes(ref_mem[idx], wd, r[7:4]);
      slave_xfer(1'b0, local_addr(idx), 32'd0, rd);
      check_value("s_prdata_o", ref_mem[idx], rd);
    end

    // core request lands in the slave's RAM request cycle
    for (i = 0; i < 8; i++) begin
      r = next_rand();
      a = r % WORDS;
      b = (r >> 8) % WORDS;
      be = r[23:20];
      wd = next_rand();
      sd = next_rand();
      fork
        slave_xfer(1'b1, local_addr(a), sd, rd_s);
        begin
          @(negedge clk);
          core_access(local_addr(b), 1'b1, be, wd, rd_c);
        end
      join
      ref_mem[a] = sd;
      ref_mem[b] = merge_lanes(ref_mem[b], wd, be);
      fork
        slave_xfer(1'b0, local_addr(a), 32'd0, rd_s);
        begin
          @(negedge clk);
          core_access(local_addr(b), 1'b0, 4'hF, 32'd0, rd_c);
        end
      join
      check_value("s_prdata_o", ref_mem[a], rd_s);
      check_value("lsu_rdata_o", ref_mem[b], rd_c);
    end

    repeat (2) @(negedge clk);
    if (u_dut.u_chk.fail_count != 0) begin
      $display("ERRORS FOUND");
      $fatal(1, "protocol assertion failed");
    end else begin
      $display("NO ERRORS");
      $finish;
    end
  end

endmodule
